//--- bench/decode_checker.sv
`timescale 1ns/1ps
`default_nettype none

module decode_checker (
    input  wire                            clk_i,
    input  wire                            rst_i,
    input  wire                            instr_valid_i,
    input  wire rv_isa_pkg::xlen_t         instr_i,
    input  wire rv_isa_pkg::xlen_t         instr_pc_i,
    input  wire                            rf_we_i,
    input  wire rv_isa_pkg::reg_idx_t      rf_waddr_i,
    input  wire rv_isa_pkg::xlen_t         rf_wdata_i,
    input  wire                            csr_we_i,
    input  wire rv_isa_pkg::csr_addr_t     csr_waddr_i,
    input  wire rv_isa_pkg::xlen_t         csr_wdata_i,
    input  wire                            exe_valid_i,
    input  wire pipe_pkg::stage2_exe_bus_t exe_bus_i,
    output int                             errors_o,
    output int                             checks_o,
    output int                             pending_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    xlen_t           regs_m [32];
    xlen_t           csr_m [csr_addr_t];  // only implemented addresses get an entry
    xlen_t           instr_q [$];
    xlen_t           pc_q [$];
    logic [1:0]      valid_pipe;
    xlen_t           cur_instr, cur_pc;
    stage2_exe_bus_t expected;
    int              errors = 0;
    int              checks = 0;
    int              pending = 0;

    assign errors_o  = errors;
    assign checks_o  = checks;
    assign pending_o = pending;

    function automatic logic branch_taken(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic xlen_t csr_read(input csr_addr_t a);
        return csr_m.exists(a) ? csr_m[a] : '0;
    endfunction

    // expected execute bus, built from the instruction and the mirrored state
    function automatic stage2_exe_bus_t expected_bus(input xlen_t ins, input xlen_t pc);
        logic [2:0] f3;
        logic [11:0] f12;
        xlen_t      imm, src1, src2;
        logic [3:0] mem_re, mem_we;
        alu_op_t    alu_op;
        logic       rfm, rfc, gr_we, jump, branch, excp, xret, brk;
        csr_addr_t  csr_a;
        f3     = ins[14:12];
        f12    = ins[31:20];
        imm    = {{20{ins[31]}}, ins[31:20]};
        src1   = regs_m[ins[19:15]];
        mem_re = '0;
        mem_we = '0;
        alu_op = {ALU_CL_INT, 3'b000};
        rfm    = 1'b0;
        rfc    = 1'b0;
        gr_we  = 1'b1;
        jump   = 1'b0;
        branch = 1'b0;
        excp   = 1'b0;
        xret   = 1'b0;
        brk    = 1'b0;
        csr_a  = '0;
        case (ins[6:0])
            OPC_LUI: begin
                imm  = {ins[31:12], 12'b0};
                src1 = '0;
            end
            OPC_AUIPC: begin
                imm  = {ins[31:12], 12'b0};
                src1 = pc;
            end
            OPC_JAL: begin
                imm  = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
                src1 = pc;
                jump = 1'b1;
            end
            OPC_JALR: jump = 1'b1;
            OPC_BRANCH: begin
                imm    = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                src1   = pc;
                alu_op = {ALU_CL_BR, f3};
                gr_we  = 1'b0;
                branch = branch_taken(f3, regs_m[ins[19:15]], regs_m[ins[24:20]]);
            end
            OPC_LOAD: begin
                mem_re = {1'b1, f3};
                rfm    = 1'b1;
            end
            OPC_STORE: begin
                imm    = {{20{ins[31]}}, ins[31:25], ins[11:7]};
                mem_we = {1'b1, f3};
                gr_we  = 1'b0;
            end
            OPC_OP_IMM: alu_op = {(f3 == 3'b101 && ins[30]) ? ALU_CL_ALT : ALU_CL_INT, f3};
            OPC_OP:     alu_op = {ins[30] ? ALU_CL_ALT : ALU_CL_INT, f3};
            OPC_SYSTEM: begin
                if (f3 == 3'b001 || f3 == 3'b010) begin
                    rfc    = 1'b1;
                    csr_a  = f12;
                    alu_op = {ALU_CL_CSR, f3};
                end else if (f3 == 3'b000 && f12 == 12'h001) begin
                    brk = 1'b1;
                end else if (f3 == 3'b000 && f12 == 12'h302) begin
                    xret = 1'b1;
                end else begin
                    excp = 1'b1;  // ecall and every other system encoding
                end
            end
            default: excp = 1'b1;
        endcase
        src2 = (ins[6:0] == OPC_OP) ? regs_m[ins[24:20]] : imm;
        return {csr_read(csr_a), mem_re, mem_we, pc, alu_op, rfm, rfc, gr_we, ins[11:7],
                src1, src2, csr_a, jump | branch, excp, xret, brk};
    endfunction

    // outputs are settled at the falling edge, write ports land on the next rising edge
    always @(negedge clk_i) begin
        if (rst_i) begin
            foreach (regs_m[i]) begin
                regs_m[i] = '0;
            end
            csr_m.delete();
            instr_q.delete();
            pc_q.delete();
            valid_pipe = '0;
        end else begin
            if (exe_valid_i !== valid_pipe[1]) begin
                errors++;
                if (valid_pipe[1]) begin
                    $display("exe_valid_o stayed low at %0t for an accepted instruction", $time);
                end else begin
                    $display("exe_valid_o was high at %0t with no instruction behind it", $time);
                end
            end
            if (valid_pipe[1]) begin
                cur_instr = instr_q.pop_front();
                cur_pc    = pc_q.pop_front();
                if (exe_valid_i) begin
                    expected = expected_bus(cur_instr, cur_pc);
                    checks++;
                    if (exe_bus_i !== expected) begin
                        errors++;
                        $display("Mismatch at %0t: instr %h pc %h bus %h expected %h",
                                 $time, cur_instr, cur_pc, exe_bus_i, expected);
                    end
                end
            end
            if (rf_we_i && rf_waddr_i != '0) begin
                regs_m[rf_waddr_i] = rf_wdata_i;
            end
            if (csr_we_i && csr_waddr_i inside {CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH,
                                                CSR_MEPC, CSR_MCAUSE}) begin
                csr_m[csr_waddr_i] = csr_wdata_i;
            end
            valid_pipe = {valid_pipe[0], instr_valid_i};
            if (instr_valid_i) begin
                instr_q.push_back(instr_i);
                pc_q.push_back(instr_pc_i);
            end
        end
        pending = instr_q.size();
    end

endmodule

`default_nettype wire

//--- bench/tb_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic            clk_i;
    logic            rst_i;
    logic            instr_valid_i;
    xlen_t           instr_i, instr_pc_i;
    logic            rf_we_i;
    reg_idx_t        rf_waddr_i;
    xlen_t           rf_wdata_i;
    logic            csr_we_i;
    csr_addr_t       csr_waddr_i;
    xlen_t           csr_wdata_i;
    stage2_exe_bus_t exe_bus_o;
    logic            exe_valid_o;
    int              errors, checks, pending;
    int              bench_errors = 0;
    int              base_errors, base_checks;
    xlen_t           pc;

    opcode_e    operand_ops [6] = '{OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC, OPC_LOAD, OPC_STORE};
    logic [2:0] branch_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    csr_addr_t  csr_list [6] = '{CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
                                 12'h7c0};  // last one is unimplemented

    decode_top DUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_pc_i    (instr_pc_i),
        .rf_we_i       (rf_we_i),
        .rf_waddr_i    (rf_waddr_i),
        .rf_wdata_i    (rf_wdata_i),
        .csr_we_i      (csr_we_i),
        .csr_waddr_i   (csr_waddr_i),
        .csr_wdata_i   (csr_wdata_i),
        .exe_bus_o     (exe_bus_o),
        .exe_valid_o   (exe_valid_o)
    );

    decode_checker u_checker (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_pc_i    (instr_pc_i),
        .rf_we_i       (rf_we_i),
        .rf_waddr_i    (rf_waddr_i),
        .rf_wdata_i    (rf_wdata_i),
        .csr_we_i      (csr_we_i),
        .csr_waddr_i   (csr_waddr_i),
        .csr_wdata_i   (csr_wdata_i),
        .exe_valid_i   (exe_valid_o),
        .exe_bus_i     (exe_bus_o),
        .errors_o      (errors),
        .checks_o      (checks),
        .pending_o     (pending)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic xlen_t rand_instr(input logic [6:0] opc);
        xlen_t r;
        r = $urandom();
        return {r[31:7], opc};
    endfunction

    function automatic xlen_t set_fields(input xlen_t ins, input logic [2:0] f3,
                                         input reg_idx_t rs1, input reg_idx_t rs2);
        return {ins[31:25], rs2, rs1, f3, ins[11:7], ins[6:0]};
    endfunction

    function automatic xlen_t csr_instr(input csr_addr_t addr, input logic [2:0] f3);
        xlen_t r;
        r = $urandom();
        return {addr, r[19:15], f3, r[11:7], 7'b1110011};
    endfunction

    // one clock, inputs move 1 ns after the edge and strobes drop
    task automatic step();
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b0;
        rf_we_i       = 1'b0;
        csr_we_i      = 1'b0;
    endtask

    task automatic put_instr(input xlen_t ins);
        instr_valid_i = 1'b1;
        instr_i       = ins;
        instr_pc_i    = pc;
        pc            = pc + 32'd4;
    endtask

    task automatic put_reg(input reg_idx_t addr, input xlen_t data);
        rf_we_i    = 1'b1;
        rf_waddr_i = addr;
        rf_wdata_i = data;
    endtask

    task automatic send(input xlen_t ins);
        put_instr(ins);
        step();
    endtask

    task automatic write_reg(input reg_idx_t addr, input xlen_t data);
        put_reg(addr, data);
        step();
    endtask

    task automatic write_csr(input csr_addr_t addr, input xlen_t data);
        csr_we_i    = 1'b1;
        csr_waddr_i = addr;
        csr_wdata_i = data;
        step();
    endtask

    task automatic begin_test();
        base_errors = errors + bench_errors;
        base_checks = checks;
    endtask

    task automatic end_test(input string name);
        int waited;
        waited = 0;
        while (pending != 0 && waited < 20) begin
            step();
            waited++;
        end
        if (pending != 0) begin
            bench_errors++;
            $display("timeout in %s: %0d instructions never reached the execute stage",
                     name, pending);
        end
        $display("test %s: %0d checks, %0d errors", name, checks - base_checks,
                 errors + bench_errors - base_errors);
    endtask

    initial begin
        void'($urandom(32'hb38983ce));
        rst_i         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        instr_pc_i    = '0;
        rf_we_i       = 1'b0;
        rf_waddr_i    = '0;
        rf_wdata_i    = '0;
        csr_we_i      = 1'b0;
        csr_waddr_i   = '0;
        csr_wdata_i   = '0;
        pc            = 32'h0000_1000;
        repeat (5) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        begin_test();
        repeat (3) step();  // idle, the checker expects exe_valid_o low
        for (int i = 0; i < 4; i++) begin
            send(rand_instr(operand_ops[$urandom_range(5, 0)]));
        end
        repeat (2) step();
        send(rand_instr(OPC_OP));
        step();
        send(rand_instr(OPC_LUI));
        end_test("reset and valid timing");

        begin_test();
        for (int r = 1; r < 32; r++) begin
            write_reg(reg_idx_t'(r), $urandom());
        end
        for (int i = 0; i < 40; i++) begin
            send(rand_instr(operand_ops[$urandom_range(5, 0)]));
            if ($urandom_range(3, 0) == 0) begin
                step();
            end
        end
        end_test("operand select");

        begin_test();
        write_reg(5'd5, 32'h1234_5678);
        write_reg(5'd6, 32'h1234_5678);
        write_reg(5'd7, 32'h8000_0000);  // most negative against +1
        write_reg(5'd8, 32'h0000_0001);
        foreach (branch_f3[k]) begin
            send(set_fields(rand_instr(OPC_BRANCH), branch_f3[k],
                            reg_idx_t'($urandom_range(31, 0)), reg_idx_t'($urandom_range(31, 0))));
            send(set_fields(rand_instr(OPC_BRANCH), branch_f3[k], 5'd5, 5'd6));
            send(set_fields(rand_instr(OPC_BRANCH), branch_f3[k], 5'd7, 5'd8));
            send(set_fields(rand_instr(OPC_BRANCH), branch_f3[k], 5'd8, 5'd7));
        end
        send(rand_instr(OPC_JAL));
        send(rand_instr(OPC_JALR));
        end_test("branch resolution");

        begin_test();
        foreach (csr_list[k]) begin
            write_csr(csr_list[k], $urandom());
        end
        foreach (csr_list[k]) begin
            send(csr_instr(csr_list[k], 3'b001));
            send(csr_instr(csr_list[k], 3'b010));
        end
        end_test("csr path");

        begin_test();
        send(32'h0000_0073);  // ecall
        send(32'h0010_0073);  // ebreak
        send(32'h3020_0073);  // mret
        send(32'h1050_0073);
        send(set_fields(rand_instr(OPC_SYSTEM), 3'b100, 5'd1, 5'd2));
        send(rand_instr(7'b0001011));
        end_test("system and illegal");

        begin_test();
        write_reg(5'd0, $urandom());
        send(set_fields(rand_instr(OPC_OP), 3'b000, 5'd0, 5'd0));
        put_instr(set_fields(rand_instr(OPC_OP), 3'b000, 5'd9, 5'd10));
        put_reg(5'd9, $urandom());
        step();
        write_reg(5'd10, $urandom());
        write_reg(5'd10, $urandom());
        write_reg(5'd9, $urandom());  // lands after the check cycle
        end_test("x0 and write visibility");

        $display("summary: %0d checks, %0d errors", checks, errors + bench_errors);
        if (errors + bench_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- common/pipe_pkg.sv
`default_nettype none
`include "riscv_macros.svh"

package pipe_pkg;

    typedef logic [`STAGE_1_2_BUS_WIDTH-1:0]   stage12_bus_t;
    typedef logic [`STAGE_2_EXE_BUS_WIDTH-1:0] stage2_exe_bus_t;

    // bit 3 requests the access, bits 2:0 are the load/store funct3
    typedef logic [`RV_MEM_CTRL_W-1:0] mem_ctrl_t;

    // bit 1 conditional branch, bit 0 unconditional jump
    typedef logic [1:0] jmp_opt_t;

    localparam jmp_opt_t JMP_NONE   = 2'b00;
    localparam jmp_opt_t JMP_JUMP   = 2'b01;
    localparam jmp_opt_t JMP_BRANCH = 2'b10;

endpackage

`default_nettype wire

//--- common/riscv_macros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

`define RV_XLEN         32
`define RV_REG_AW       5
`define RV_CSR_AW       12
`define RV_ALUOP_W      6   // low 3 bits double as the compare function
`define RV_NUM_REGS     32
`define RV_MEM_CTRL_W   4   // {access, funct3}

// stage 1 to 2 bus, packed fields sit in the low bits and the rest is spare
`define STAGE_1_2_USED_WIDTH    115
`define STAGE_1_2_BUS_WIDTH     128

`define STAGE_2_EXE_BUS_WIDTH   166

`endif

//--- common/rv_isa_pkg.sv
`default_nettype none
`include "riscv_macros.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0]    xlen_t;
    typedef logic [`RV_REG_AW-1:0]  reg_idx_t;
    typedef logic [`RV_CSR_AW-1:0]  csr_addr_t;
    typedef logic [`RV_ALUOP_W-1:0] alu_op_t;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // same encoding as branch funct3
    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } cmp_fn_e;

    typedef enum logic [2:0] {
        SYS_PRIV  = 3'b000,
        SYS_CSRRW = 3'b001,
        SYS_CSRRS = 3'b010
    } sys_f3_e;

    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_MRET   = 12'h302;

    // alu_op[5:3], the low bits carry funct3
    localparam logic [2:0] ALU_CL_INT = 3'b000;
    localparam logic [2:0] ALU_CL_ALT = 3'b001;  // sub, sra, srai
    localparam logic [2:0] ALU_CL_CSR = 3'b010;
    localparam logic [2:0] ALU_CL_BR  = 3'b100;  // target add, compare in [2:0]

    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

endpackage

`default_nettype wire

//--- decode/decode_stage_1.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_macros.svh"

module decode_stage_1 (
    input  wire                     clk_i,
    input  wire                     rst_i,
    input  wire                     instr_valid_i,
    input  wire rv_isa_pkg::xlen_t  instr_i,
    input  wire rv_isa_pkg::xlen_t  instr_pc_i,
    output logic                    decode_stage_1_valid_o,
    output pipe_pkg::stage12_bus_t  decode_stage_1_2_bus_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    opcode_e      opcode;
    logic [2:0]   funct3;
    logic         funct7_5;
    xlen_t        imm_i, imm_s, imm_b, imm_u, imm_j;
    xlen_t        imm;
    mem_ctrl_t    mem_re, mem_we;
    logic [2:0]   flush_flags;
    logic         excp_flush, xret_flush, break_signal;
    jmp_opt_t     jmp_option;
    reg_idx_t     rs1;
    alu_op_t      alu_op;
    logic         src1_is_pc, src2_is_imm, res_from_mem, res_from_csr, gr_we;
    csr_addr_t    csr_addr;
    stage12_bus_t bus_d;

    assign opcode   = opcode_e'(instr_i[6:0]);
    assign funct3   = instr_i[14:12];
    assign funct7_5 = instr_i[30];

    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        imm          = imm_i;
        mem_re       = '0;
        mem_we       = '0;
        excp_flush   = 1'b0;
        xret_flush   = 1'b0;
        break_signal = 1'b0;
        jmp_option   = JMP_NONE;
        rs1          = instr_i[19:15];
        alu_op       = {ALU_CL_INT, 3'b000};  // add
        src1_is_pc   = 1'b0;
        src2_is_imm  = 1'b1;
        res_from_mem = 1'b0;
        res_from_csr = 1'b0;
        gr_we        = 1'b1;
        csr_addr     = '0;
        case (opcode)
            OPC_LUI: begin
                imm = imm_u;
                rs1 = '0;                     // x0 + imm
            end
            OPC_AUIPC: begin
                imm        = imm_u;
                src1_is_pc = 1'b1;
            end
            OPC_JAL: begin
                imm        = imm_j;
                src1_is_pc = 1'b1;
                jmp_option = JMP_JUMP;
            end
            OPC_JALR: jmp_option = JMP_JUMP;
            OPC_BRANCH: begin
                imm        = imm_b;
                src1_is_pc = 1'b1;            // pc + imm is the target
                jmp_option = JMP_BRANCH;
                alu_op     = {ALU_CL_BR, funct3};
                gr_we      = 1'b0;
            end
            OPC_LOAD: begin
                mem_re       = {1'b1, funct3};
                res_from_mem = 1'b1;
            end
            OPC_STORE: begin
                imm    = imm_s;
                mem_we = {1'b1, funct3};
                gr_we  = 1'b0;
            end
            OPC_OP_IMM: begin
                // only srai takes the alternate form, the other funct7 bits are imm
                alu_op = {(funct3 == 3'b101 && funct7_5) ? ALU_CL_ALT : ALU_CL_INT, funct3};
            end
            OPC_OP: begin
                src2_is_imm = 1'b0;
                alu_op      = {funct7_5 ? ALU_CL_ALT : ALU_CL_INT, funct3};
            end
            OPC_SYSTEM: begin
                case (funct3)
                    SYS_CSRRW, SYS_CSRRS: begin
                        res_from_csr = 1'b1;
                        csr_addr     = instr_i[31:20];
                        alu_op       = {ALU_CL_CSR, funct3};
                    end
                    SYS_PRIV: begin
                        if (instr_i[31:20] == F12_ECALL) begin
                            excp_flush = 1'b1;
                        end else if (instr_i[31:20] == F12_EBREAK) begin
                            break_signal = 1'b1;
                        end else if (instr_i[31:20] == F12_MRET) begin
                            xret_flush = 1'b1;
                        end else begin
                            excp_flush = 1'b1;
                        end
                    end
                    default: excp_flush = 1'b1;
                endcase
            end
            default: excp_flush = 1'b1;       // illegal opcode
        endcase
    end

    assign flush_flags = {excp_flush, xret_flush, break_signal};

    assign bus_d = {
        {(`STAGE_1_2_BUS_WIDTH - `STAGE_1_2_USED_WIDTH){1'b0}},
        imm, mem_re, mem_we, flush_flags, jmp_option,
        rs1, instr_i[24:20], instr_i[11:7], alu_op,
        src1_is_pc, src2_is_imm, res_from_mem, res_from_csr, gr_we,
        csr_addr, instr_pc_i
    };

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            decode_stage_1_valid_o <= 1'b0;
            decode_stage_1_2_bus_o <= '0;
        end else begin
            decode_stage_1_valid_o <= instr_valid_i;
            if (instr_valid_i) begin
                decode_stage_1_2_bus_o <= bus_d;
            end
        end
    end

    // ecall, ebreak and mret are exclusive, execute picks one trap path
    a_flush_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        instr_valid_i |-> $onehot0(flush_flags));

endmodule

`default_nettype wire

//--- decode/decode_stage_2.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_macros.svh"

module decode_stage_2 (
    input  wire                         clk_i,
    input  wire                         rst_i,
    input  wire                         decode_stage_1_valid_i,
    input  wire pipe_pkg::stage12_bus_t decode_stage_1_2_bus_i,
    output rv_isa_pkg::csr_addr_t       csr_addr_o,
    input  wire rv_isa_pkg::xlen_t      csr_value_i,
    output rv_isa_pkg::reg_idx_t        rs1_o,
    output rv_isa_pkg::reg_idx_t        rs2_o,
    input  wire rv_isa_pkg::xlen_t      rs1_value_i,
    input  wire rv_isa_pkg::xlen_t      rs2_value_i,
    output pipe_pkg::stage2_exe_bus_t   exe_bus_o,
    output logic                        valid_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    stage12_bus_t bus_q;
    xlen_t        pc, imm;
    mem_ctrl_t    mem_re, mem_we;
    logic         excp_flush, xret_flush, break_signal;
    jmp_opt_t     jmp_option;
    reg_idx_t     rd;
    alu_op_t      alu_op;
    logic         src1_is_pc, src2_is_imm, res_from_mem, res_from_csr, gr_we;
    csr_addr_t    csr_addr;
    xlen_t        cmp_result, src1, src2;
    logic         jmp_flag;

    assign {
        imm, mem_re, mem_we, excp_flush, xret_flush, break_signal, jmp_option,
        rs1_o, rs2_o, rd, alu_op,
        src1_is_pc, src2_is_imm, res_from_mem, res_from_csr, gr_we,
        csr_addr, pc
    } = bus_q[`STAGE_1_2_USED_WIDTH-1:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
            bus_q   <= '0;
        end else begin
            valid_o <= decode_stage_1_valid_i;
            if (decode_stage_1_valid_i) begin
                bus_q <= decode_stage_1_2_bus_i;
            end
        end
    end

    compare u_compare (
        .compare_a_i  (rs1_value_i),
        .compare_b_i  (rs2_value_i),
        .compare_fn_i (cmp_fn_e'(alu_op[2:0])),
        .compare_o    (cmp_result)
    );

    assign jmp_flag = (cmp_result[0] && jmp_option[1]) || jmp_option[0];

    assign src1 = src1_is_pc ? pc : rs1_value_i;
    assign src2 = src2_is_imm ? imm : rs2_value_i;

    assign csr_addr_o = csr_addr;

    assign exe_bus_o = {
        csr_value_i,    // 165:134
        mem_re,         // 133:130
        mem_we,         // 129:126
        pc,             // 125:94
        alu_op,         // 93:88
        res_from_mem,   // 87
        res_from_csr,   // 86
        gr_we,          // 85
        rd,             // 84:80
        src1,           // 79:48
        src2,           // 47:16
        csr_addr,       // 15:4
        jmp_flag,       // 3
        excp_flush,     // 2
        xret_flush,     // 1
        break_signal    // 0
    };

    a_valid_known: assert property (@(posedge clk_i) disable iff (rst_i)
        !$isunknown(valid_o));

endmodule

`default_nettype wire

//--- filelist.f
+incdir+common
common/rv_isa_pkg.sv
common/pipe_pkg.sv
rtl/compare.sv
rtl/reg_file.sv
rtl/csr_file.sv
decode/decode_stage_1.sv
decode/decode_stage_2.sv
rtl/decode_top.sv
bench/decode_checker.sv
bench/tb_decode_top.sv

//--- rtl/compare.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_macros.svh"

module compare (
    input  wire rv_isa_pkg::xlen_t   compare_a_i,
    input  wire rv_isa_pkg::xlen_t   compare_b_i,
    input  wire rv_isa_pkg::cmp_fn_e compare_fn_i,
    output rv_isa_pkg::xlen_t        compare_o
);
    import rv_isa_pkg::*;

    logic hit;

    always_comb begin
        case (compare_fn_i)
            CMP_EQ:  hit = (compare_a_i == compare_b_i);
            CMP_NE:  hit = (compare_a_i != compare_b_i);
            CMP_LT:  hit = ($signed(compare_a_i) < $signed(compare_b_i));
            CMP_GE:  hit = ($signed(compare_a_i) >= $signed(compare_b_i));
            CMP_LTU: hit = (compare_a_i < compare_b_i);
            CMP_GEU: hit = (compare_a_i >= compare_b_i);
            default: hit = 1'b0;
        endcase
    end

    assign compare_o = {{(`RV_XLEN-1){1'b0}}, hit};

endmodule

`default_nettype wire

//--- rtl/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire rv_isa_pkg::csr_addr_t raddr_i,
    output rv_isa_pkg::xlen_t          rdata_o,
    input  wire                        we_i,
    input  wire rv_isa_pkg::csr_addr_t waddr_i,
    input  wire rv_isa_pkg::xlen_t     wdata_i
);
    import rv_isa_pkg::*;

    xlen_t mstatus, mtvec, mscratch, mepc, mcause;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (we_i) begin
            case (waddr_i)
                CSR_MSTATUS:  mstatus  <= wdata_i;
                CSR_MTVEC:    mtvec    <= wdata_i;
                CSR_MSCRATCH: mscratch <= wdata_i;
                CSR_MEPC:     mepc     <= wdata_i;
                CSR_MCAUSE:   mcause   <= wdata_i;
                default: ;                            // unimplemented, dropped
            endcase
        end
    end

    always_comb begin
        case (raddr_i)
            CSR_MSTATUS:  rdata_o = mstatus;
            CSR_MTVEC:    rdata_o = mtvec;
            CSR_MSCRATCH: rdata_o = mscratch;
            CSR_MEPC:     rdata_o = mepc;
            CSR_MCAUSE:   rdata_o = mcause;
            default:      rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire                        instr_valid_i,
    input  wire rv_isa_pkg::xlen_t     instr_i,
    input  wire rv_isa_pkg::xlen_t     instr_pc_i,
    input  wire                        rf_we_i,
    input  wire rv_isa_pkg::reg_idx_t  rf_waddr_i,
    input  wire rv_isa_pkg::xlen_t     rf_wdata_i,
    input  wire                        csr_we_i,
    input  wire rv_isa_pkg::csr_addr_t csr_waddr_i,
    input  wire rv_isa_pkg::xlen_t     csr_wdata_i,
    output pipe_pkg::stage2_exe_bus_t  exe_bus_o,
    output logic                       exe_valid_o
);
    import rv_isa_pkg::*;
    import pipe_pkg::*;

    logic         s1_valid;
    stage12_bus_t s1_bus;
    csr_addr_t    csr_raddr;
    xlen_t        csr_rdata;
    reg_idx_t     rs1, rs2;
    xlen_t        rs1_value, rs2_value;

    decode_stage_1 u_decode_stage_1 (
        .clk_i                  (clk_i),
        .rst_i                  (rst_i),
        .instr_valid_i          (instr_valid_i),
        .instr_i                (instr_i),
        .instr_pc_i             (instr_pc_i),
        .decode_stage_1_valid_o (s1_valid),
        .decode_stage_1_2_bus_o (s1_bus)
    );

    decode_stage_2 u_decode_stage_2 (
        .clk_i                  (clk_i),
        .rst_i                  (rst_i),
        .decode_stage_1_valid_i (s1_valid),
        .decode_stage_1_2_bus_i (s1_bus),
        .csr_addr_o             (csr_raddr),
        .csr_value_i            (csr_rdata),
        .rs1_o                  (rs1),
        .rs2_o                  (rs2),
        .rs1_value_i            (rs1_value),
        .rs2_value_i            (rs2_value),
        .exe_bus_o              (exe_bus_o),
        .valid_o                (exe_valid_o)
    );

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .rdata1_o (rs1_value),
        .rdata2_o (rs2_value),
        .we_i     (rf_we_i),
        .waddr_i  (rf_waddr_i),
        .wdata_i  (rf_wdata_i)
    );

    csr_file u_csr_file (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .raddr_i (csr_raddr),
        .rdata_o (csr_rdata),
        .we_i    (csr_we_i),
        .waddr_i (csr_waddr_i),
        .wdata_i (csr_wdata_i)
    );

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_macros.svh"

module reg_file (
    input  wire                      clk_i,
    input  wire                      rst_i,
    input  wire rv_isa_pkg::reg_idx_t raddr1_i,
    input  wire rv_isa_pkg::reg_idx_t raddr2_i,
    output rv_isa_pkg::xlen_t        rdata1_o,
    output rv_isa_pkg::xlen_t        rdata2_o,
    input  wire                      we_i,
    input  wire rv_isa_pkg::reg_idx_t waddr_i,
    input  wire rv_isa_pkg::xlen_t    wdata_i
);
    import rv_isa_pkg::*;

    xlen_t regs [`RV_NUM_REGS];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin  // x0 never written
            regs[waddr_i] <= wdata_i;
        end
    end

    // no bypass, a write shows up on the next cycle
    assign rdata1_o = regs[raddr1_i];
    assign rdata2_o = regs[raddr2_i];

    a_x0_rd1: assert property (@(posedge clk_i) disable iff (rst_i)
        (raddr1_i == '0) |-> (rdata1_o == '0));
    a_x0_rd2: assert property (@(posedge clk_i) disable iff (rst_i)
        (raddr2_i == '0) |-> (rdata2_o == '0));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_decode_top -o sim_decode

./obj_dir/sim_decode | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
